/* flist.f */
verilog/ooo_pkg.sv
verilog/register_file.sv
verilog/rename_table.sv
verilog/reorder_buffer.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/ooo_core_top.sv
testbench/tb_ooo_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_ooo_core -f flist.f -o tb_ooo_core \
    && ./obj_dir/tb_ooo_core > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^Test OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/tb_ooo_core.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_ooo_core;

    localparam int num_instrs = 400;
    localparam int cycle_limit = num_instrs * (ooo_pkg::mul_cycles + ooo_pkg::rob_depth) + 200;

    localparam int mode_chain = 1;
    localparam int mode_mixed = 2;
    localparam int mode_zero = 3;

    logic clk = 1'b0;
    logic reset;
    logic dispatch_valid;
    ooo_pkg::dispatch_instr_t dispatch_instr;
    logic core_full;
    ooo_pkg::retire_t retire;

    integer seed;
    int cycle_count = 0;
    int dispatched = 0;
    int retired = 0;
    logic saw_full = 1'b0;
    logic [ooo_pkg::xlen-1:0] model_regs [ooo_pkg::arch_regs];
    ooo_pkg::retire_t expected_q [$];
    ooo_pkg::retire_t expected_item;
    ooo_pkg::dispatch_instr_t instr;
    logic [ooo_pkg::reg_idx_len-1:0] prev_rd;

    ooo_core_top dut (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .core_full      (core_full),
        .retire         (retire)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    // in-order reference of one instruction
    function automatic logic [31:0] model_result(input ooo_pkg::dispatch_instr_t ins);
        logic [31:0] a;
        logic [31:0] b;
        a = (ins.rs1 == 4'd0) ? 32'h0 : model_regs[ins.rs1];
        if (ins.use_imm) begin
            b = {{16{ins.imm[15]}}, ins.imm};
        end else begin
            b = (ins.rs2 == 4'd0) ? 32'h0 : model_regs[ins.rs2];
        end
        case (ins.op)
            ooo_pkg::op_add: return a + b;
            ooo_pkg::op_sub: return a - b;
            ooo_pkg::op_and: return a & b;
            ooo_pkg::op_or:  return a | b;
            ooo_pkg::op_xor: return a ^ b;
            ooo_pkg::op_sll: return a << b[4:0];
            ooo_pkg::op_mul: return a * b;
            default:         return 32'h0;
        endcase
    endfunction

    function automatic ooo_pkg::dispatch_instr_t random_instr(input int mode,
            input logic [3:0] last_rd);
        ooo_pkg::dispatch_instr_t ins;
        logic [31:0] r;
        r = $random(seed);
        ins.op = ooo_pkg::alu_op_t'(r[2:0] % 3'd7);
        ins.rd = r[7:4];
        ins.rs1 = r[11:8];
        ins.rs2 = r[15:12];
        ins.use_imm = r[16] & r[17];
        ins.imm = 16'($random(seed));
        case (mode)
            mode_chain: begin
                // read the previous destination
                ins.rs1 = last_rd;
                if (r[18]) begin
                    ins.rs2 = last_rd;
                end
                if (ins.rd == 4'd0) begin
                    ins.rd = 4'd1;
                end
                ins.use_imm = r[16];
            end
            mode_mixed: begin
                if (r[19:18] == 2'd0) begin
                    ins.op = ooo_pkg::op_mul;
                end
            end
            mode_zero: begin
                if (r[18]) begin
                    ins.rd = 4'd0;
                end
                if (r[19]) begin
                    ins.rs1 = 4'd0;
                end
                if (r[20]) begin
                    ins.rs2 = 4'd0;
                end
                ins.use_imm = r[21];
            end
            default: begin
            end
        endcase
        return ins;
    endfunction

    // entered and left 1 ns after a rising edge
    task automatic send(input ooo_pkg::dispatch_instr_t ins);
        ooo_pkg::retire_t item;
        while (core_full) begin
            saw_full = 1'b1;
            @(posedge clk);
            #1;
        end
        dispatch_valid = 1'b1;
        dispatch_instr = ins;
        item.valid = 1'b1;
        item.rd = ins.rd;
        item.value = model_result(ins);
        expected_q.push_back(item);
        if (ins.rd != 4'd0) begin
            model_regs[ins.rd] = item.value;
        end
        dispatched++;
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles with %0d retirements pending",
                                        cycle_count, expected_q.size()));
        end
    end

    // retire port checker
    always @(negedge clk) begin
        if (!reset && retire.valid) begin
            if (expected_q.size() == 0) begin
                stop_with_failure("a retirement appeared with no instruction pending");
            end else begin
                expected_item = expected_q.pop_front();
                check_value("retire.rd", 32'(retire.rd), 32'(expected_item.rd));
                check_value("retire.value", retire.value, expected_item.value);
                retired++;
            end
        end
    end

    initial begin
        seed = 79;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_instr = '0;
        for (int i = 0; i < ooo_pkg::arch_regs; i++) begin
            model_regs[i] = 32'h0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // quiet core after reset
        repeat (6) begin
            @(posedge clk);
            #1;
            check_value("core_full", 32'(core_full), 32'h0);
        end

        instr = '0;
        instr.op = ooo_pkg::op_add;
        instr.rd = 4'd1;
        instr.use_imm = 1'b1;
        instr.imm = 16'h8123;
        send(instr);
        wait_drain();

        prev_rd = 4'd1;
        for (int i = 0; i < 49; i++) begin
            instr = random_instr(mode_chain, prev_rd);
            send(instr);
            prev_rd = instr.rd;
        end

        for (int i = 0; i < 150; i++) begin
            send(random_instr(mode_mixed, prev_rd));
            idle($unsigned($random(seed)) % 4);
        end

        // back to back, only core_full holds it
        saw_full = 1'b0;
        for (int i = 0; i < 100; i++) begin
            send(random_instr(mode_mixed, prev_rd));
        end
        if (!saw_full) begin
            stop_with_failure("core_full never rose during the back-to-back burst");
        end

        for (int i = 0; i < 100; i++) begin
            send(random_instr(mode_zero, prev_rd));
            idle($unsigned($random(seed)) % 2);
        end

        wait_drain();
        idle(10);
        check_value("core_full", 32'(core_full), 32'h0);
        if (retired == dispatched && dispatched == num_instrs) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d instructions dispatched but %0d retired",
                                        dispatched, retired));
        end
    end

endmodule

`default_nettype wire

/* verilog/ooo_core_top.sv */
`default_nettype none
`timescale 1ns/100ps

module ooo_core_top (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic dispatch_valid,
    input  wire ooo_pkg::dispatch_instr_t dispatch_instr,
    output logic core_full,
    output ooo_pkg::retire_t retire
);

    ooo_pkg::map_entry_t rs1_map;
    ooo_pkg::map_entry_t rs2_map;
    ooo_pkg::cdb_t cdb;
    ooo_pkg::rs_entry_t issue_entry;
    logic [ooo_pkg::xlen-1:0] rf_rs1_value;
    logic [ooo_pkg::xlen-1:0] rf_rs2_value;
    logic [ooo_pkg::xlen-1:0] rs1_value;
    logic [ooo_pkg::xlen-1:0] rs2_value;
    logic [ooo_pkg::rob_tag_len-1:0] alloc_tag;
    logic rob_full;
    logic rs_full;
    logic exec_stall;

    assign core_full = rob_full || rs_full;

    register_file u_register_file (
        .clk       (clk),
        .reset     (reset),
        .rs1_idx   (dispatch_instr.rs1),
        .rs2_idx   (dispatch_instr.rs2),
        .rs1_value (rf_rs1_value),
        .rs2_value (rf_rs2_value),
        .retire    (retire)
    );

    rename_table u_rename_table (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .alloc_tag      (alloc_tag),
        .cdb            (cdb),
        .retire         (retire),
        .rs1_map        (rs1_map),
        .rs2_map        (rs2_map)
    );

    reorder_buffer u_reorder_buffer (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .rs1_map        (rs1_map),
        .rs2_map        (rs2_map),
        .rf_rs1_value   (rf_rs1_value),
        .rf_rs2_value   (rf_rs2_value),
        .cdb            (cdb),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .retire         (retire)
    );

    reservation_station u_reservation_station (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .alloc_tag      (alloc_tag),
        .rs1_map        (rs1_map),
        .rs2_map        (rs2_map),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .cdb            (cdb),
        .exec_stall     (exec_stall),
        .rs_full        (rs_full),
        .issue_entry    (issue_entry)
    );

    alu_unit u_alu_unit (
        .clk         (clk),
        .reset       (reset),
        .issue_entry (issue_entry),
        .exec_stall  (exec_stall),
        .cdb         (cdb)
    );

endmodule

`default_nettype wire

/* verilog/alu_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module alu_unit (
    input  wire logic clk,
    input  wire logic reset,
    input  wire ooo_pkg::rs_entry_t issue_entry,
    output logic exec_stall,
    output ooo_pkg::cdb_t cdb
);

    logic [$clog2(ooo_pkg::mul_cycles):0] mul_count;
    logic [ooo_pkg::rob_tag_len-1:0] mul_tag;
    logic [ooo_pkg::xlen-1:0] mul_value;
    logic accept;

    function automatic logic [ooo_pkg::xlen-1:0] alu_result(
        input ooo_pkg::alu_op_t op,
        input logic [ooo_pkg::xlen-1:0] a,
        input logic [ooo_pkg::xlen-1:0] b
    );
        case (op)
            ooo_pkg::op_add: return a + b;
            ooo_pkg::op_sub: return a - b;
            ooo_pkg::op_and: return a & b;
            ooo_pkg::op_or:  return a | b;
            ooo_pkg::op_xor: return a ^ b;
            ooo_pkg::op_sll: return a << b[4:0];
            // low word of the product only
            ooo_pkg::op_mul: return a * b;
            default:         return '0;
        endcase
    endfunction

    // busy while a multiply counts down
    assign exec_stall = (mul_count != '0);
    assign accept = issue_entry.valid && !exec_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            cdb.valid <= 1'b0;
            mul_count <= '0;
        end else begin
            cdb.valid <= 1'b0;
            if (mul_count != '0) begin
                mul_count <= mul_count - 1'b1;
                if (mul_count == ($clog2(ooo_pkg::mul_cycles) + 1)'(1)) begin
                    cdb.valid <= 1'b1;
                    cdb.tag <= mul_tag;
                    cdb.value <= mul_value;
                end
            end else if (accept) begin
                if (issue_entry.op == ooo_pkg::op_mul) begin
                    mul_count <= ($clog2(ooo_pkg::mul_cycles) + 1)'(ooo_pkg::mul_cycles - 1);
                    mul_tag <= issue_entry.rd_tag;
                    mul_value <= alu_result(issue_entry.op, issue_entry.rs1_value,
                                            issue_entry.rs2_value);
                end else begin
                    cdb.valid <= 1'b1;
                    cdb.tag <= issue_entry.rd_tag;
                    cdb.value <= alu_result(issue_entry.op, issue_entry.rs1_value,
                                            issue_entry.rs2_value);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/reservation_station.sv */
`default_nettype none
`timescale 1ns/100ps

module reservation_station (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic dispatch_valid,
    input  wire ooo_pkg::dispatch_instr_t dispatch_instr,
    input  wire logic [ooo_pkg::rob_tag_len-1:0] alloc_tag,
    input  wire ooo_pkg::map_entry_t rs1_map,
    input  wire ooo_pkg::map_entry_t rs2_map,
    input  wire logic [ooo_pkg::xlen-1:0] rs1_value,
    input  wire logic [ooo_pkg::xlen-1:0] rs2_value,
    input  wire ooo_pkg::cdb_t cdb,
    input  wire logic exec_stall,
    output logic rs_full,
    output ooo_pkg::rs_entry_t issue_entry
);

    ooo_pkg::rs_entry_t slots [ooo_pkg::rs_depth];
    ooo_pkg::rs_entry_t candidate;
    logic [ooo_pkg::birthday_len-1:0] next_birthday;
    logic [ooo_pkg::birthday_len-1:0] oldest_birthday;
    logic [$clog2(ooo_pkg::rs_depth)-1:0] free_slot;
    logic [$clog2(ooo_pkg::rs_depth)-1:0] issue_slot;
    logic has_free;
    logic found_ready;
    logic accept;
    logic src1_ready;
    logic src2_ready;

    // incoming entry with operands already resolved
    always_comb begin
        src1_ready = (dispatch_instr.rs1 == '0) || (rs1_map.tag == '0) || rs1_map.ready;
        src2_ready = dispatch_instr.use_imm || (rs2_map.tag == '0) || rs2_map.ready;

        candidate.valid = 1'b1;
        candidate.ready = src1_ready && src2_ready;
        candidate.rs1_ready = src1_ready;
        candidate.rs2_ready = src2_ready;
        candidate.rs1_tag = rs1_map.tag;
        candidate.rs2_tag = dispatch_instr.use_imm ? '0 : rs2_map.tag;
        candidate.rd_tag = alloc_tag;
        candidate.rs1_value = rs1_value;
        if (dispatch_instr.use_imm) begin
            candidate.rs2_value = (ooo_pkg::xlen)'($signed(dispatch_instr.imm));
        end else begin
            candidate.rs2_value = rs2_value;
        end
        candidate.birthday = next_birthday;
        candidate.op = dispatch_instr.op;
    end

    // lowest free slot
    always_comb begin
        has_free = 1'b0;
        free_slot = '0;
        for (int i = ooo_pkg::rs_depth - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                has_free = 1'b1;
                free_slot = i[$clog2(ooo_pkg::rs_depth)-1:0];
            end
        end
    end

    assign rs_full = !has_free;

    // oldest ready entry wins
    always_comb begin
        oldest_birthday = ooo_pkg::max_birthday;
        found_ready = 1'b0;
        issue_slot = '0;
        for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
            if (slots[i].valid && slots[i].ready &&
                    (!found_ready || slots[i].birthday < oldest_birthday)) begin
                oldest_birthday = slots[i].birthday;
                issue_slot = i[$clog2(ooo_pkg::rs_depth)-1:0];
                found_ready = 1'b1;
            end
        end
    end

    always_comb begin
        issue_entry = slots[issue_slot];
        issue_entry.valid = found_ready;
        issue_entry.ready = found_ready;
    end

    assign accept = found_ready && !exec_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
                slots[i].valid <= 1'b0;
            end
            next_birthday <= '0;
        end else begin
            // both sources may match one broadcast
            for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
                if (cdb.valid && slots[i].valid) begin
                    if (!slots[i].rs1_ready && slots[i].rs1_tag == cdb.tag) begin
                        slots[i].rs1_value <= cdb.value;
                        slots[i].rs1_ready <= 1'b1;
                    end
                    if (!slots[i].rs2_ready && slots[i].rs2_tag == cdb.tag) begin
                        slots[i].rs2_value <= cdb.value;
                        slots[i].rs2_ready <= 1'b1;
                    end
                    slots[i].ready <= (slots[i].rs1_ready || slots[i].rs1_tag == cdb.tag) &&
                                      (slots[i].rs2_ready || slots[i].rs2_tag == cdb.tag);
                end
            end

            if (accept) begin
                slots[issue_slot].valid <= 1'b0;
            end

            if (dispatch_valid && has_free) begin
                slots[free_slot] <= candidate;
                next_birthday <= next_birthday + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`default_nettype none
`timescale 1ns/100ps

module reorder_buffer (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic dispatch_valid,
    input  wire ooo_pkg::dispatch_instr_t dispatch_instr,
    input  wire ooo_pkg::map_entry_t rs1_map,
    input  wire ooo_pkg::map_entry_t rs2_map,
    input  wire logic [ooo_pkg::xlen-1:0] rf_rs1_value,
    input  wire logic [ooo_pkg::xlen-1:0] rf_rs2_value,
    input  wire ooo_pkg::cdb_t cdb,
    output logic [ooo_pkg::rob_tag_len-1:0] alloc_tag,
    output logic rob_full,
    output logic [ooo_pkg::xlen-1:0] rs1_value,
    output logic [ooo_pkg::xlen-1:0] rs2_value,
    output ooo_pkg::retire_t retire
);

    logic [ooo_pkg::reg_idx_len-1:0] rd_mem [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0] value_mem [ooo_pkg::rob_depth];
    logic [ooo_pkg::rob_depth-1:0] done;
    logic [$clog2(ooo_pkg::rob_depth)-1:0] head;
    logic [$clog2(ooo_pkg::rob_depth)-1:0] tail;
    logic [ooo_pkg::rob_tag_len-1:0] count;
    logic head_cdb_hit;
    logic head_retire;

    // tags are slot index + 1
    function automatic logic [$clog2(ooo_pkg::rob_depth)-1:0] slot_of(
        input logic [ooo_pkg::rob_tag_len-1:0] tag
    );
        logic [ooo_pkg::rob_tag_len-1:0] diff;
        diff = tag - 1'b1;
        return diff[$clog2(ooo_pkg::rob_depth)-1:0];
    endfunction

    function automatic logic [ooo_pkg::xlen-1:0] resolve(
        input ooo_pkg::map_entry_t src,
        input logic [ooo_pkg::xlen-1:0] rf_value
    );
        if (src.tag == '0) begin
            return rf_value;
        end else if (cdb.valid && cdb.tag == src.tag) begin
            return cdb.value;
        end
        return value_mem[slot_of(src.tag)];
    endfunction

    assign alloc_tag = (ooo_pkg::rob_tag_len)'(tail) + 1'b1;
    assign rob_full = (count == (ooo_pkg::rob_tag_len)'(ooo_pkg::rob_depth));

    always_comb begin
        rs1_value = resolve(rs1_map, rf_rs1_value);
        rs2_value = resolve(rs2_map, rf_rs2_value);
    end

    // head may retire straight off the bus
    assign head_cdb_hit = cdb.valid && slot_of(cdb.tag) == head;
    assign head_retire = (count != '0) && (done[head] || head_cdb_hit);

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            rd_mem[tail] <= dispatch_instr.rd;
        end
        if (cdb.valid) begin
            value_mem[slot_of(cdb.tag)] <= cdb.value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            done <= '0;
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= head_retire;
            if (cdb.valid) begin
                done[slot_of(cdb.tag)] <= 1'b1;
            end
            if (head_retire) begin
                retire.rd <= rd_mem[head];
                retire.value <= done[head] ? value_mem[head] : cdb.value;
                done[head] <= 1'b0;
                head <= head + 1'b1;
            end
            if (dispatch_valid) begin
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end

            case ({dispatch_valid, head_retire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rename_table.sv */
`default_nettype none
`timescale 1ns/100ps

module rename_table (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic dispatch_valid,
    input  wire ooo_pkg::dispatch_instr_t dispatch_instr,
    input  wire logic [ooo_pkg::rob_tag_len-1:0] alloc_tag,
    input  wire ooo_pkg::cdb_t cdb,
    input  wire ooo_pkg::retire_t retire,
    output ooo_pkg::map_entry_t rs1_map,
    output ooo_pkg::map_entry_t rs2_map
);

    ooo_pkg::map_entry_t map [ooo_pkg::arch_regs];

    // retirement follows allocation order, so the retiring tag is tracked here
    logic [ooo_pkg::rob_tag_len-1:0] retire_tag;

    function automatic ooo_pkg::map_entry_t lookup(
        input logic [ooo_pkg::reg_idx_len-1:0] idx
    );
        ooo_pkg::map_entry_t entry;
        entry = map[idx];
        // same-cycle broadcast counts as ready
        if (cdb.valid && entry.tag != '0 && cdb.tag == entry.tag) begin
            entry.ready = 1'b1;
        end
        return entry;
    endfunction

    always_comb begin
        rs1_map = lookup(dispatch_instr.rs1);
        rs2_map = lookup(dispatch_instr.rs2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::arch_regs; i++) begin
                map[i] <= '0;
            end
            retire_tag <= (ooo_pkg::rob_tag_len)'(1);
        end else begin
            for (int i = 0; i < ooo_pkg::arch_regs; i++) begin
                if (cdb.valid && map[i].tag != '0 && map[i].tag == cdb.tag) begin
                    map[i].ready <= 1'b1;
                end
            end

            if (retire.valid) begin
                if (retire_tag == (ooo_pkg::rob_tag_len)'(ooo_pkg::rob_depth)) begin
                    retire_tag <= (ooo_pkg::rob_tag_len)'(1);
                end else begin
                    retire_tag <= retire_tag + 1'b1;
                end
                // only clear if no younger writer has taken the register
                if (map[retire.rd].tag == retire_tag) begin
                    map[retire.rd] <= '0;
                end
            end

            // new mapping wins over a retire clear of the same register
            if (dispatch_valid && dispatch_instr.rd != '0) begin
                map[dispatch_instr.rd].tag <= alloc_tag;
                map[dispatch_instr.rd].ready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`default_nettype none
`timescale 1ns/100ps

module register_file (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic [ooo_pkg::reg_idx_len-1:0] rs1_idx,
    input  wire logic [ooo_pkg::reg_idx_len-1:0] rs2_idx,
    output logic [ooo_pkg::xlen-1:0] rs1_value,
    output logic [ooo_pkg::xlen-1:0] rs2_value,
    input  wire ooo_pkg::retire_t retire
);

    logic [ooo_pkg::xlen-1:0] regs [ooo_pkg::arch_regs];

    // r0 reads as zero
    assign rs1_value = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_value = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::arch_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.rd != '0) begin
            regs[retire.rd] <= retire.value;
        end
    end

endmodule

`default_nettype wire

/* verilog/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    localparam int xlen = 32;
    localparam int imm_len = 16;

    localparam int arch_regs = 16;
    localparam int reg_idx_len = 4;

    // tag 0 means the value sits in the register file
    localparam int rob_depth = 8;
    localparam int rob_tag_len = 4;

    localparam int rs_depth = 4;

    localparam int birthday_len = 6;
    localparam logic [birthday_len-1:0] max_birthday = '1;

    localparam int mul_cycles = 4;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_mul
    } alu_op_t;

    typedef struct packed {
        alu_op_t op;
        logic [reg_idx_len-1:0] rd;
        logic [reg_idx_len-1:0] rs1;
        logic [reg_idx_len-1:0] rs2;
        logic [imm_len-1:0] imm;
        // operand b comes from imm, rs2 is ignored
        logic use_imm;
    } dispatch_instr_t;

    typedef struct packed {
        logic [rob_tag_len-1:0] tag;
        logic ready;
    } map_entry_t;

    typedef struct packed {
        logic valid;
        logic [rob_tag_len-1:0] tag;
        logic [xlen-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic valid;
        logic ready;
        logic rs1_ready;
        logic rs2_ready;
        logic [rob_tag_len-1:0] rs1_tag;
        logic [rob_tag_len-1:0] rs2_tag;
        logic [rob_tag_len-1:0] rd_tag;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic [birthday_len-1:0] birthday;
        alu_op_t op;
    } rs_entry_t;

    typedef struct packed {
        logic valid;
        logic [reg_idx_len-1:0] rd;
        logic [xlen-1:0] value;
    } retire_t;

endpackage

`default_nettype wire
